//--- Makefile
TOP = tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- common/memsys_params.svh
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// data and address widths
`define XLEN 32
`define ADDR_W 32

// sram geometry, one word per entry
`define SRAM_WORDS 1024
`define SRAM_IDX_W 10

// access size codes carried in lsu_req_t.size
`define SIZE_B 2'd0
`define SIZE_H 2'd1
`define SIZE_W 2'd2

`endif

//--- common/memsys_pkg.sv
`include "memsys_params.svh"

package memsys_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`XLEN/8-1:0] strb_t;
	typedef logic [1:0] size_t;

	// word-aligned bus request, reads carry zero strobes
	typedef struct packed {
		addr_t addr;
		logic we;
		word_t wdata;
		strb_t wstrb;
	} bus_req_t;

	// byte addressed request from the execute side
	typedef struct packed {
		addr_t addr;
		logic we;
		size_t size;
		logic is_unsigned;
		word_t wdata;
	} lsu_req_t;

	typedef enum logic [1:0] {
		F_STOP,
		F_REQ,
		F_WAIT,
		F_HOLD
	} fetch_state_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_FETCH,
		ARB_DATA
	} arb_state_e;

endpackage

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fetch_req_valid,
	input  memsys_pkg::bus_req_t fetch_req,
	output logic                 fetch_req_ready,
	output logic                 fetch_rsp_valid,
	input  logic                 data_req_valid,
	input  memsys_pkg::bus_req_t data_req,
	output logic                 data_req_ready,
	output logic                 data_rsp_valid,
	output memsys_pkg::word_t    rsp_data,
	output logic                 mem_req_valid,
	output memsys_pkg::bus_req_t mem_req,
	input  logic                 mem_req_ready,
	input  logic                 mem_rsp_valid,
	input  memsys_pkg::word_t    mem_rsp_data
);

	memsys_pkg::arb_state_e state;
	logic idle;

	assign idle = (state == memsys_pkg::ARB_IDLE);

	// data side takes the bus on a tie
	assign data_req_ready = idle && mem_req_ready;
	assign fetch_req_ready = idle && !data_req_valid && mem_req_ready;

	assign mem_req_valid = idle && (data_req_valid || fetch_req_valid);

	always_comb begin
		if (data_req_valid)
			mem_req = data_req;
		else
			mem_req = fetch_req;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= memsys_pkg::ARB_IDLE;
		end else begin
			case (state)
				memsys_pkg::ARB_IDLE: begin
					if (data_req_valid && mem_req_ready)
						state <= memsys_pkg::ARB_DATA;
					else if (fetch_req_valid && mem_req_ready)
						state <= memsys_pkg::ARB_FETCH;
				end
				memsys_pkg::ARB_FETCH,
				memsys_pkg::ARB_DATA: begin
					if (mem_rsp_valid)
						state <= memsys_pkg::ARB_IDLE;
				end
				default: state <= memsys_pkg::ARB_IDLE;
			endcase
		end
	end

	// response goes back to whoever owns the bus
	assign fetch_rsp_valid = (state == memsys_pkg::ARB_FETCH) && mem_rsp_valid;
	assign data_rsp_valid = (state == memsys_pkg::ARB_DATA) && mem_rsp_valid;
	assign rsp_data = mem_rsp_data;

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 redirect_valid,
	input  memsys_pkg::addr_t    redirect_pc,
	output logic                 redirect_ready,
	output logic                 instr_valid,
	output memsys_pkg::word_t    instr,
	output memsys_pkg::addr_t    instr_pc,
	input  logic                 instr_ready,
	output logic                 fetch_req_valid,
	output memsys_pkg::bus_req_t fetch_req,
	input  logic                 fetch_req_ready,
	input  logic                 fetch_rsp_valid,
	input  memsys_pkg::word_t    rsp_data
);

	memsys_pkg::fetch_state_e state;
	memsys_pkg::addr_t pc;
	memsys_pkg::word_t instr_q;

	// a read already on the bus cannot be cancelled
	assign redirect_ready = (state != memsys_pkg::F_WAIT);
	assign fetch_req_valid = (state == memsys_pkg::F_REQ);
	assign instr_valid = (state == memsys_pkg::F_HOLD);
	assign instr = instr_q;
	assign instr_pc = pc;

	// plain word read at the pc
	always_comb begin
		fetch_req = '0;
		fetch_req.addr = pc;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= memsys_pkg::F_STOP;
			pc <= '0;
		end else if (redirect_valid && redirect_ready) begin
			state <= memsys_pkg::F_REQ;
			pc <= redirect_pc;
		end else begin
			case (state)
				memsys_pkg::F_REQ: begin
					if (fetch_req_ready)
						state <= memsys_pkg::F_WAIT;
				end
				// responses seen outside F_WAIT belong to a dropped request
				memsys_pkg::F_WAIT: begin
					if (fetch_rsp_valid)
						state <= memsys_pkg::F_HOLD;
				end
				memsys_pkg::F_HOLD: begin
					if (instr_ready) begin
						state <= memsys_pkg::F_REQ;
						pc <= pc + 32'd4;
					end
				end
				default: state <= memsys_pkg::F_STOP;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == memsys_pkg::F_WAIT && fetch_rsp_valid)
			instr_q <= rsp_data;
	end

endmodule

//--- hw/lsu.sv
`timescale 1ns/1ps
`include "memsys_params.svh"

module lsu (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 lsu_req_valid,
	input  memsys_pkg::lsu_req_t lsu_req,
	output logic                 lsu_req_ready,
	output logic                 lsu_rsp_valid,
	output memsys_pkg::word_t    lsu_rsp_data,
	output logic                 data_req_valid,
	output memsys_pkg::bus_req_t data_req,
	input  logic                 data_req_ready,
	input  logic                 data_rsp_valid,
	input  memsys_pkg::word_t    rsp_data
);

	logic busy;
	logic [1:0] off_q;
	memsys_pkg::size_t size_q;
	logic uns_q;
	logic we_q;
	logic [1:0] off;
	memsys_pkg::strb_t strb;
	memsys_pkg::word_t shifted;

	assign off = lsu_req.addr[1:0];

	// one access at a time
	assign data_req_valid = lsu_req_valid && !busy;
	assign lsu_req_ready = !busy && data_req_ready;

	// strobes follow size and byte offset, loads carry none
	always_comb begin
		case (lsu_req.size)
			`SIZE_B: strb = 4'b0001 << off;
			`SIZE_H: strb = 4'b0011 << off;
			default: strb = 4'b1111;
		endcase
		if (!lsu_req.we)
			strb = '0;
	end

	always_comb begin
		data_req.addr = {lsu_req.addr[`ADDR_W-1:2], 2'b00};
		data_req.we = lsu_req.we;
		data_req.wdata = lsu_req.wdata << {off, 3'b000};
		data_req.wstrb = strb;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			busy <= 1'b0;
		else if (lsu_req_valid && lsu_req_ready)
			busy <= 1'b1;
		else if (data_rsp_valid)
			busy <= 1'b0;
	end

	// access shape kept for the response
	always_ff @(posedge clk) begin
		if (lsu_req_valid && lsu_req_ready) begin
			off_q <= off;
			size_q <= lsu_req.size;
			uns_q <= lsu_req.is_unsigned;
			we_q <= lsu_req.we;
		end
	end

	assign lsu_rsp_valid = busy && data_rsp_valid;
	assign shifted = rsp_data >> {off_q, 3'b000};

	always_comb begin
		case (size_q)
			`SIZE_B: lsu_rsp_data = {{24{shifted[7] && !uns_q}}, shifted[7:0]};
			`SIZE_H: lsu_rsp_data = {{16{shifted[15] && !uns_q}}, shifted[15:0]};
			default: lsu_rsp_data = rsp_data;
		endcase
		// stores answer with zero
		if (we_q)
			lsu_rsp_data = '0;
	end

endmodule

//--- hw/memsys_top.sv
`timescale 1ns/1ps

module memsys_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 redirect_valid,
	input  memsys_pkg::addr_t    redirect_pc,
	output logic                 redirect_ready,
	output logic                 instr_valid,
	output memsys_pkg::word_t    instr,
	output memsys_pkg::addr_t    instr_pc,
	input  logic                 instr_ready,
	input  logic                 lsu_req_valid,
	input  memsys_pkg::lsu_req_t lsu_req,
	output logic                 lsu_req_ready,
	output logic                 lsu_rsp_valid,
	output memsys_pkg::word_t    lsu_rsp_data
);

	// fetch side
	logic fetch_req_valid;
	memsys_pkg::bus_req_t fetch_req;
	logic fetch_req_ready;
	logic fetch_rsp_valid;
	// data side
	logic data_req_valid;
	memsys_pkg::bus_req_t data_req;
	logic data_req_ready;
	logic data_rsp_valid;
	memsys_pkg::word_t rsp_data;
	// arbiter to sram
	logic mem_req_valid;
	memsys_pkg::bus_req_t mem_req;
	logic mem_req_ready;
	logic mem_rsp_valid;
	memsys_pkg::word_t mem_rsp_data;

	fetch_unit i_fetch_unit (
		.clk(clk),
		.rst_n(rst_n),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.redirect_ready(redirect_ready),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_ready(instr_ready),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req(fetch_req),
		.fetch_req_ready(fetch_req_ready),
		.fetch_rsp_valid(fetch_rsp_valid),
		.rsp_data(rsp_data)
	);

	lsu i_lsu (
		.clk(clk),
		.rst_n(rst_n),
		.lsu_req_valid(lsu_req_valid),
		.lsu_req(lsu_req),
		.lsu_req_ready(lsu_req_ready),
		.lsu_rsp_valid(lsu_rsp_valid),
		.lsu_rsp_data(lsu_rsp_data),
		.data_req_valid(data_req_valid),
		.data_req(data_req),
		.data_req_ready(data_req_ready),
		.data_rsp_valid(data_rsp_valid),
		.rsp_data(rsp_data)
	);

	bus_arbiter i_bus_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req(fetch_req),
		.fetch_req_ready(fetch_req_ready),
		.fetch_rsp_valid(fetch_rsp_valid),
		.data_req_valid(data_req_valid),
		.data_req(data_req),
		.data_req_ready(data_req_ready),
		.data_rsp_valid(data_rsp_valid),
		.rsp_data(rsp_data),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data)
	);

	sram i_sram (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data)
	);

endmodule

//--- hw/sram.sv
`timescale 1ns/1ps
`include "memsys_params.svh"

module sram (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_req_valid,
	input  memsys_pkg::bus_req_t mem_req,
	output logic                 mem_req_ready,
	output logic                 mem_rsp_valid,
	output memsys_pkg::word_t    mem_rsp_data
);

	memsys_pkg::word_t mem [`SRAM_WORDS];
	memsys_pkg::word_t rdata_q;
	logic pending;
	logic [`SRAM_IDX_W-1:0] idx;
	logic accept;

	assign idx = mem_req.addr[`SRAM_IDX_W+1:2];
	assign mem_req_ready = !pending;
	assign accept = mem_req_valid && mem_req_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else
			pending <= accept;
	end

	// read sees the old word, writes land at the same edge
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= mem_req.we ? '0 : mem[idx];
			for (int i = 0; i < `XLEN/8; i++) begin
				if (mem_req.we && mem_req.wstrb[i])
					mem[idx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
			end
		end
	end

	assign mem_rsp_valid = pending;
	assign mem_rsp_data = rdata_q;

endmodule

//--- tb.f
+incdir+common
common/memsys_pkg.sv
hw/fetch_unit.sv
hw/lsu.sv
hw/bus_arbiter.sv
hw/sram.sv
hw/memsys_top.sv
test/memsys_chk.sv
test/tb_top.sv

//--- test/memsys_chk.sv
`timescale 1ns/1ps
`include "memsys_params.svh"

module memsys_chk (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 lsu_req_valid,
	input memsys_pkg::lsu_req_t lsu_req,
	input logic                 lsu_req_ready,
	input logic                 redirect_valid,
	input logic                 redirect_ready,
	input logic                 instr_valid,
	input memsys_pkg::word_t    instr,
	input memsys_pkg::addr_t    instr_pc,
	input logic                 instr_ready,
	input logic                 mem_req_valid,
	input logic                 mem_req_ready,
	input logic                 mem_rsp_valid,
	input logic                 fetch_req_valid,
	input logic                 fetch_req_ready,
	input logic                 fetch_rsp_valid
);

	// halfwords on even bytes, words on four-byte boundaries
	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_req_valid && lsu_req_ready |->
			!(lsu_req.size == `SIZE_H && lsu_req.addr[0])
			&& !(lsu_req.size == `SIZE_W && lsu_req.addr[1:0] != 2'b00))
		else $error("misaligned load/store accepted");

	// a redirect may drop the held instruction
	a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid && !instr_ready && !(redirect_valid && redirect_ready) |=>
			instr_valid && $stable(instr) && $stable(instr_pc))
		else $error("held instruction changed before handoff");

	// one request outstanding, answered on the next cycle
	a_one_pending: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid && mem_req_ready |=> mem_rsp_valid && !mem_req_valid)
		else $error("new sram request offered with a response pending");

	// redirect_ready drops only for a read in flight, a redirect wins over it
	a_redirect_fall: assert property (@(posedge clk) disable iff (!rst_n)
		redirect_ready |=> redirect_ready
			!= $past(fetch_req_valid && fetch_req_ready && !redirect_valid))
		else $error("redirect_ready fell without an accepted fetch");

	a_redirect_rise: assert property (@(posedge clk) disable iff (!rst_n)
		!redirect_ready |=> redirect_ready == $past(fetch_rsp_valid))
		else $error("redirect_ready out of step with the fetch response");

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps
`include "memsys_params.svh"

module tb_top;

	localparam int N_WORD = 150;
	localparam int N_SUB = 300;
	localparam int N_FETCH = 120;
	localparam int N_REDIR = 20;
	localparam int N_CONC = 150;
	localparam int N_TRANS = `SRAM_WORDS + 3 * N_WORD + 2 * N_SUB + N_FETCH
		+ 6 * N_REDIR + 2 * N_CONC;

	logic clk = 1'b0;
	logic rst_n;
	logic redirect_valid;
	memsys_pkg::addr_t redirect_pc;
	logic redirect_ready;
	logic instr_valid;
	memsys_pkg::word_t instr;
	memsys_pkg::addr_t instr_pc;
	logic instr_ready;
	logic lsu_req_valid;
	memsys_pkg::lsu_req_t lsu_req;
	logic lsu_req_ready;
	logic lsu_rsp_valid;
	memsys_pkg::word_t lsu_rsp_data;

	memsys_pkg::word_t model [`SRAM_WORDS];
	logic [31:0] lfsr = 32'hd00692e5;
	memsys_pkg::addr_t exp_pc;
	logic redirected = 1'b0;
	int acc_count = 0;
	int rsp_count = 0;

	memsys_top i_memsys_top (.*);

	bind memsys_top memsys_chk i_memsys_chk (
		.clk(clk),
		.rst_n(rst_n),
		.lsu_req_valid(lsu_req_valid),
		.lsu_req(lsu_req),
		.lsu_req_ready(lsu_req_ready),
		.redirect_valid(redirect_valid),
		.redirect_ready(redirect_ready),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_ready(instr_ready),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_rsp_valid(mem_rsp_valid),
		.fetch_req_valid(fetch_req_valid),
		.fetch_req_ready(fetch_req_ready),
		.fetch_rsp_valid(fetch_rsp_valid)
	);

	always #4 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic memsys_pkg::size_t rand_size();
		logic [31:0] r;
		r = take_bits(2);
		return (r[1:0] == 2'd3) ? `SIZE_W : r[1:0];
	endfunction

	// byte address in one half of the sram, aligned to the size
	function automatic memsys_pkg::addr_t rand_addr(input logic upper,
			input memsys_pkg::size_t sz);
		memsys_pkg::addr_t a;
		a = {20'd0, upper, 11'd0} | (take_bits(11) & 32'h7ff);
		if (sz == `SIZE_H)
			a[0] = 1'b0;
		if (sz == `SIZE_W)
			a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic memsys_pkg::addr_t rand_pc();
		logic [31:0] r;
		r = take_bits(8);
		return {22'd0, r[7:0], 2'b00};
	endfunction

	function automatic memsys_pkg::word_t expect_load(input memsys_pkg::addr_t a,
			input memsys_pkg::size_t sz, input logic uns);
		memsys_pkg::word_t w;
		w = model[a[`SRAM_IDX_W+1:2]] >> {a[1:0], 3'b000};
		case (sz)
			`SIZE_B: return {{24{w[7] & ~uns}}, w[7:0]};
			`SIZE_H: return {{16{w[15] & ~uns}}, w[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic store_model(input memsys_pkg::addr_t a, input memsys_pkg::size_t sz,
			input memsys_pkg::word_t d);
		int n;
		int off;
		n = (sz == `SIZE_B) ? 1 : (sz == `SIZE_H) ? 2 : 4;
		off = int'(a[1:0]);
		for (int b = 0; b < n; b++)
			model[a[`SRAM_IDX_W+1:2]][(off + b) * 8 +: 8] = d[b * 8 +: 8];
	endtask

	task automatic lsu_access(input memsys_pkg::addr_t a, input logic we,
			input memsys_pkg::size_t sz, input logic uns, input memsys_pkg::word_t d);
		@(negedge clk);
		lsu_req_valid = 1'b1;
		lsu_req = '{addr: a, we: we, size: sz, is_unsigned: uns, wdata: d};
		@(posedge clk);
		while (!lsu_req_ready)
			@(posedge clk);
		acc_count++;
		if (we)
			store_model(a, sz, d);
		@(negedge clk);
		lsu_req_valid = 1'b0;
		while (!lsu_rsp_valid)
			@(negedge clk);
		check("lsu_rsp_data", lsu_rsp_data, we ? 32'd0 : expect_load(a, sz, uns));
	endtask

	task automatic random_access(input logic upper);
		memsys_pkg::size_t sz;
		logic [31:0] r;
		sz = rand_size();
		r = take_bits(4);
		// idle gaps let the fetch side win the bus now and then
		repeat (r[3:2])
			@(negedge clk);
		lsu_access(rand_addr(upper, sz), r[0], sz, r[1], take_bits(32));
	endtask

	task automatic redirect_to(input memsys_pkg::addr_t pc);
		@(negedge clk);
		instr_ready = 1'b0;
		redirect_valid = 1'b1;
		redirect_pc = pc;
		@(posedge clk);
		while (!redirect_ready)
			@(posedge clk);
		exp_pc = pc;
		redirected = 1'b1;
		@(negedge clk);
		redirect_valid = 1'b0;
	endtask

	// take n instructions with random back-pressure
	task automatic consume(input int n);
		int got;
		logic [31:0] r;
		got = 0;
		while (got < n) begin
			@(negedge clk);
			r = take_bits(1);
			instr_ready = r[0];
			@(posedge clk);
			if (instr_valid && instr_ready) begin
				check("instr_pc", instr_pc, exp_pc);
				check("instr", instr, model[exp_pc[`SRAM_IDX_W+1:2]]);
				exp_pc = exp_pc + 32'd4;
				got++;
			end
		end
		@(negedge clk);
		instr_ready = 1'b0;
	endtask

	always @(posedge clk) begin
		if (rst_n && lsu_rsp_valid)
			rsp_count++;
		if (rst_n && !redirected)
			check("instr_valid before redirect", {31'd0, instr_valid}, 32'd0);
	end

	initial begin
		repeat (16 + N_TRANS * 40) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", 16 + N_TRANS * 40);
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		memsys_pkg::addr_t a;
		memsys_pkg::addr_t la;
		memsys_pkg::size_t sz;
		memsys_pkg::size_t lsz;
		logic [31:0] r;
		rst_n = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		instr_ready = 1'b0;
		lsu_req_valid = 1'b0;
		lsu_req = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check("redirect_ready", {31'd0, redirect_ready}, 32'd1);
		check("instr_valid", {31'd0, instr_valid}, 32'd0);
		check("lsu_rsp_valid", {31'd0, lsu_rsp_valid}, 32'd0);
		check("lsu_req_ready", {31'd0, lsu_req_ready}, 32'd1);
		repeat (20) @(posedge clk);

		// whole sram gets known contents first
		for (int i = 0; i < `SRAM_WORDS; i++)
			lsu_access(memsys_pkg::addr_t'(i * 4), 1'b1, `SIZE_W, 1'b0, take_bits(32));

		repeat (N_WORD) begin
			a = rand_addr(1'b0, `SIZE_W);
			lsu_access(a, 1'b1, `SIZE_W, 1'b0, take_bits(32));
			lsu_access(a, 1'b0, `SIZE_W, 1'b0, '0);
			lsu_access(rand_addr(1'b0, `SIZE_W), 1'b0, `SIZE_W, 1'b0, '0);
		end

		// narrow store, then a load of any size from the same word
		repeat (N_SUB) begin
			sz = rand_size();
			a = rand_addr(1'b0, sz);
			lsu_access(a, 1'b1, sz, 1'b0, take_bits(32));
			lsz = rand_size();
			la = rand_addr(1'b0, lsz);
			la[`SRAM_IDX_W+1:2] = a[`SRAM_IDX_W+1:2];
			r = take_bits(1);
			lsu_access(la, 1'b0, lsz, r[0], '0);
		end

		redirect_to(rand_pc());
		consume(N_FETCH);

		// redirect while an instruction is held
		repeat (N_REDIR) begin
			redirect_to(rand_pc());
			while (!instr_valid)
				@(posedge clk);
			a = rand_pc();
			// a new target, so a kept instruction would show up as a wrong pc
			if (a == exp_pc)
				a = a ^ 32'h40;
			redirect_to(a);
			consume(4);
		end

		// fetch from the lower half, data traffic in the upper half
		redirect_to(rand_pc());
		fork
			consume(N_CONC);
			repeat (N_CONC) random_access(1'b1);
		join

		repeat (4) @(posedge clk);
		check("lsu_rsp_valid count", rsp_count, acc_count);
		$display("Regression passed");
		$finish;
	end

endmodule
